//--- list.f
source/panel_pkg.sv
source/framebuffer.sv
source/fillarea_walker.sv
source/fillrect_cmd.sv
source/panel_fill_top.sv
test/panel_fill_checker.sv
test/panel_fill_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then checks the log for the pass message
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module panel_fill_tb -f list.f -o panel_fill_sim

./obj_dir/panel_fill_sim | tee sim.log

grep -q "^Test passed$" sim.log

//--- source/fillarea_walker.sv
// ========================================
// Fields must stay stable while walk_enable is high; needs a reset between fills
// ========================================
`default_nettype none

module fillarea_walker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  walk_enable,
    input  panel_pkg::col_field_t x1,
    input  panel_pkg::row_field_t y1,
    input  panel_pkg::col_field_t width,
    input  panel_pkg::row_field_t height,
    input  panel_pkg::color_t     color,
    output logic                  write_enable,
    output panel_pkg::fb_addr_t   write_addr,
    output logic [7:0]            write_data,
    output logic                  ram_access_start,
    output logic                  walk_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WRITE,
        ST_DONE
    } state_t;

    typedef logic [panel_pkg::COL_FIELD_BITS:0] col_sum_t;
    typedef logic [panel_pkg::ROW_FIELD_BITS:0] row_sum_t;
    typedef logic [panel_pkg::COL_BITS:0] col_end_t;
    typedef logic [panel_pkg::ROW_BITS:0] row_end_t;

    state_t                 state;
    col_sum_t               col_sum;
    row_sum_t               row_sum;
    col_end_t               col_end;
    row_end_t               row_end;
    logic                   fill_empty;
    panel_pkg::col_addr_t   col_start;
    panel_pkg::col_addr_t   col_last;
    panel_pkg::row_addr_t   row_last;
    panel_pkg::col_addr_t   col;
    panel_pkg::row_addr_t   row;
    panel_pkg::pixel_byte_t pix;
    logic                   last_byte;
    logic                   last_col;
    logic                   last_row;

    // Clipped exclusive bounds of the rectangle
    always_comb begin
        col_sum = {1'b0, x1} + {1'b0, width};
        row_sum = {1'b0, y1} + {1'b0, height};
        col_end = (col_sum > col_sum_t'(panel_pkg::PANEL_COLUMNS)) ?
                  col_end_t'(panel_pkg::PANEL_COLUMNS) : col_end_t'(col_sum);
        row_end = (row_sum > row_sum_t'(panel_pkg::PANEL_ROWS)) ?
                  row_end_t'(panel_pkg::PANEL_ROWS) : row_end_t'(row_sum);
        fill_empty = (x1 >= panel_pkg::col_field_t'(panel_pkg::PANEL_COLUMNS)) ||
                     (y1 >= panel_pkg::row_field_t'(panel_pkg::PANEL_ROWS)) ||
                     (width == '0) || (height == '0);
    end

    assign last_byte = pix == panel_pkg::PIXEL_BYTE_MSB;
    assign last_col  = col == col_last;
    assign last_row  = row == row_last;

    assign write_enable     = state == ST_WRITE;
    assign ram_access_start = state == ST_ACCESS;
    assign walk_done        = state == ST_DONE;
    assign write_addr       = {row, col, pix};
    assign write_data       = color[panel_pkg::PIXEL_BYTE_MSB - pix];   // MSB byte at offset 0

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (walk_enable) begin
                        col_start <= panel_pkg::col_addr_t'(x1);
                        col       <= panel_pkg::col_addr_t'(x1);
                        row       <= panel_pkg::row_addr_t'(y1);
                        pix       <= '0;
                        col_last  <= panel_pkg::col_addr_t'(col_end - 1'b1);
                        row_last  <= panel_pkg::row_addr_t'(row_end - 1'b1);
                        state     <= fill_empty ? ST_DONE : ST_ACCESS;
                    end
                end
                ST_ACCESS: state <= ST_WRITE;
                ST_WRITE: begin
                    if (!last_byte) begin
                        pix <= pix + 1'b1;
                    end else begin
                        pix <= '0;
                        if (!last_col) begin
                            col <= col + 1'b1;
                        end else begin
                            col <= col_start;   // Wrap to the clipped left edge
                            if (last_row) begin
                                state <= ST_DONE;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    write_in_panel: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> (int'(write_addr.col) < panel_pkg::PANEL_COLUMNS) &&
                         (int'(write_addr.row) < panel_pkg::PANEL_ROWS));

endmodule

`default_nettype wire

//--- source/fillrect_cmd.sv
// ========================================
// Bytes are taken only while ready_for_data is high, one command per fill
// done pulses two cycles after the walker finishes and input reopens one cycle later
// ========================================
`default_nettype none

module fillrect_cmd (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          data_in,
    input  logic                enable,
    output logic                ready_for_data,
    output logic                done,
    output logic                write_enable,
    output panel_pkg::fb_addr_t write_addr,
    output logic [7:0]          write_data,
    output logic                ram_access_start
);

    typedef enum logic [3:0] {
        ST_X1,
        ST_Y1,
        ST_WIDTH,
        ST_HEIGHT,
        ST_COLOR,
        ST_START,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } state_t;

    state_t                 state;
    logic                   byte_take;
    logic                   walk_enable;
    logic                   walk_done;
    logic                   local_reset;
    panel_pkg::col_byte_t   field_cnt;
    panel_pkg::pixel_byte_t color_cnt;
    panel_pkg::col_field_t  x1;
    panel_pkg::col_field_t  width;
    panel_pkg::row_field_t  y1;
    panel_pkg::row_field_t  height;
    panel_pkg::color_t      color;

    assign byte_take = enable && ready_for_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_X1;
            ready_for_data <= 1'b1;
            done           <= 1'b0;
            walk_enable    <= 1'b0;
            local_reset    <= 1'b0;
            field_cnt      <= panel_pkg::COL_BYTE_FIRST;
            color_cnt      <= panel_pkg::PIXEL_BYTE_MSB;
        end else begin
            case (state)
                ST_X1: begin
                    if (byte_take) begin
                        x1[field_cnt*8 +: 8] <= data_in;   // MSB byte arrives first
                        if (field_cnt == '0) begin
                            field_cnt <= panel_pkg::COL_BYTE_FIRST;
                            state     <= ST_Y1;
                        end else begin
                            field_cnt <= field_cnt - 1'b1;
                        end
                    end
                end
                ST_Y1: begin
                    if (byte_take) begin
                        y1    <= data_in;
                        state <= ST_WIDTH;
                    end
                end
                ST_WIDTH: begin
                    if (byte_take) begin
                        width[field_cnt*8 +: 8] <= data_in;
                        if (field_cnt == '0) begin
                            field_cnt <= panel_pkg::COL_BYTE_FIRST;
                            state     <= ST_HEIGHT;
                        end else begin
                            field_cnt <= field_cnt - 1'b1;
                        end
                    end
                end
                ST_HEIGHT: begin
                    if (byte_take) begin
                        height <= data_in;
                        state  <= ST_COLOR;
                    end
                end
                ST_COLOR: begin
                    if (byte_take) begin
                        color[color_cnt] <= data_in;
                        if (color_cnt == '0) begin
                            color_cnt      <= panel_pkg::PIXEL_BYTE_MSB;
                            ready_for_data <= 1'b0;   // Closes on the last command byte
                            state          <= ST_START;
                        end else begin
                            color_cnt <= color_cnt - 1'b1;
                        end
                    end
                end
                ST_START: begin
                    walk_enable <= 1'b1;
                    state       <= ST_RUNNING;
                end
                ST_RUNNING: begin
                    if (walk_done) begin
                        walk_enable <= 1'b0;
                        local_reset <= 1'b1;   // Returns the walker to idle
                        state       <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    local_reset <= 1'b0;
                    done        <= 1'b1;
                    state       <= ST_DONE;
                end
                ST_DONE: begin
                    done           <= 1'b0;
                    ready_for_data <= 1'b1;
                    x1             <= '0;
                    width          <= '0;
                    y1             <= '0;
                    height         <= '0;
                    color          <= '0;
                    state          <= ST_X1;
                end
                default: state <= ST_X1;
            endcase
        end
    end

    fillarea_walker walker_i (
        .clk              (clk),
        .reset            (reset || local_reset),
        .walk_enable      (walk_enable),
        .x1               (x1),
        .y1               (y1),
        .width            (width),
        .height           (height),
        .color            (color),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .ram_access_start (ram_access_start),
        .walk_done        (walk_done)
    );

    done_single_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

`default_nettype wire

//--- source/framebuffer.sv
// ========================================
// Contents are undefined until written; scan addresses off the panel read garbage
// ========================================
`default_nettype none

module framebuffer (
    input  logic                clk,
    input  logic                write_enable,
    input  panel_pkg::fb_addr_t write_addr,
    input  logic [7:0]          write_data,
    input  panel_pkg::fb_addr_t scan_addr,
    output logic [7:0]          scan_data
);

    logic [7:0] mem [panel_pkg::FB_DEPTH];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[panel_pkg::fb_index(write_addr)] <= write_data;
        end
    end

    // Read data appears one cycle after the address
    always_ff @(posedge clk) begin
        scan_data <= mem[panel_pkg::fb_index(scan_addr)];
    end

endmodule

`default_nettype wire

//--- source/panel_fill_top.sv
// ========================================
// Single clock domain; the write port is also brought out for observation
// ========================================
`default_nettype none

module panel_fill_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          data_in,
    input  logic                enable,
    output logic                ready_for_data,
    output logic                done,
    output logic                write_enable,
    output panel_pkg::fb_addr_t write_addr,
    output logic [7:0]          write_data,
    output logic                ram_access_start,
    input  panel_pkg::fb_addr_t scan_addr,
    output logic [7:0]          scan_data
);

    fillrect_cmd cmd_i (
        .clk              (clk),
        .reset            (reset),
        .data_in          (data_in),
        .enable           (enable),
        .ready_for_data   (ready_for_data),
        .done             (done),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .ram_access_start (ram_access_start)
    );

    // The refresh side reads through the scan port only
    framebuffer fb_i (
        .clk          (clk),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .scan_addr    (scan_addr),
        .scan_data    (scan_data)
    );

endmodule

`default_nettype wire

//--- source/panel_pkg.sv
// ========================================
// Geometry is fixed at 320x32 RGB565; x1 and width travel as 16-bit MSB-first fields
// Row fields are one byte on the wire, so corners past the bottom edge still clip
// ========================================
`default_nettype none

package panel_pkg;

    localparam int PANEL_COLUMNS = 320;
    localparam int PANEL_ROWS = 32;
    localparam int BYTES_PER_PIXEL = 2;   // RGB565

    localparam int COL_BITS = 9;
    localparam int ROW_BITS = 5;

    localparam int COL_FIELD_BYTES = 2;
    localparam int COL_FIELD_BITS = 8 * COL_FIELD_BYTES;
    localparam int ROW_FIELD_BITS = 8;
    localparam int PIXEL_BITS = $clog2(BYTES_PER_PIXEL);

    // x1(2) y1(1) width(2) height(1) colour(2), multi-byte fields MSB first
    localparam int CMD_BYTES = 8;

    localparam int FB_DEPTH = PANEL_ROWS * PANEL_COLUMNS * BYTES_PER_PIXEL;
    localparam int FB_INDEX_BITS = $clog2(FB_DEPTH);

    typedef logic [COL_BITS-1:0] col_addr_t;
    typedef logic [ROW_BITS-1:0] row_addr_t;
    typedef logic [COL_FIELD_BITS-1:0] col_field_t;   // Wide enough to hold off-panel values
    typedef logic [ROW_FIELD_BITS-1:0] row_field_t;
    typedef logic [$clog2(COL_FIELD_BYTES)-1:0] col_byte_t;
    typedef logic [PIXEL_BITS-1:0] pixel_byte_t;
    typedef logic [FB_INDEX_BITS-1:0] fb_index_t;

    // Element BYTES_PER_PIXEL-1 holds the MSB byte of the colour
    typedef logic [BYTES_PER_PIXEL-1:0][7:0] color_t;

    typedef struct packed {
        row_addr_t   row;
        col_addr_t   col;
        pixel_byte_t pixel;
    } fb_addr_t;

    localparam col_byte_t COL_BYTE_FIRST = col_byte_t'(COL_FIELD_BYTES - 1);
    localparam pixel_byte_t PIXEL_BYTE_MSB = pixel_byte_t'(BYTES_PER_PIXEL - 1);

    // Linear byte offset of a framebuffer address
    function automatic fb_index_t fb_index(input fb_addr_t addr);
        int linear;
        linear = (int'(addr.row) * PANEL_COLUMNS + int'(addr.col)) * BYTES_PER_PIXEL
                 + int'(addr.pixel);
        return fb_index_t'(linear);
    endfunction

endpackage

`default_nettype wire

//--- test/panel_fill_checker.sv
// ========================================
// Parses the command stream itself; readback compares only bytes a fill has written
// ========================================
`default_nettype none

module panel_fill_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          data_in,
    input  logic                enable,
    input  logic                ready_for_data,
    input  logic                done,
    input  logic                write_enable,
    input  panel_pkg::fb_addr_t write_addr,
    input  logic [7:0]          write_data,
    input  logic                ram_access_start,
    input  panel_pkg::fb_addr_t scan_addr,
    input  logic                scan_check,
    input  logic [7:0]          scan_data,
    input  logic                end_check,
    output int                  write_errors,
    output int                  scan_errors,
    output int                  other_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]          cmd_bytes [panel_pkg::CMD_BYTES];
    logic [7:0]          model [panel_pkg::FB_DEPTH];
    bit                  written [panel_pkg::FB_DEPTH];
    panel_pkg::fb_addr_t exp_addr [$];
    logic [7:0]          exp_data [$];
    panel_pkg::fb_addr_t rd_addr_q;
    logic                rd_valid_q;
    logic                reset_q;
    logic                end_done;
    logic                closing;
    logic                closing_q;
    logic                done_q;
    logic                access_q;
    logic                write_q;
    int                  byte_count;
    int                  fills_pending;
    int                  index;

    function automatic int model_index(input int row, input int col, input int pix);
        return (row * panel_pkg::PANEL_COLUMNS + col) * panel_pkg::BYTES_PER_PIXEL + pix;
    endfunction

    // Raster order with clipping at the right and bottom edges, MSB colour byte first
    function automatic void queue_expected_writes(input int x1, input int y1, input int width,
                                                  input int height, input int color);
        int                  col_end;
        int                  row_end;
        logic [7:0]          value;
        panel_pkg::fb_addr_t addr;
        if (x1 >= panel_pkg::PANEL_COLUMNS || y1 >= panel_pkg::PANEL_ROWS) begin
            return;
        end
        col_end = (x1 + width > panel_pkg::PANEL_COLUMNS) ? panel_pkg::PANEL_COLUMNS : x1 + width;
        row_end = (y1 + height > panel_pkg::PANEL_ROWS) ? panel_pkg::PANEL_ROWS : y1 + height;
        for (int r = y1; r < row_end; r++) begin
            for (int c = x1; c < col_end; c++) begin
                for (int p = 0; p < panel_pkg::BYTES_PER_PIXEL; p++) begin
                    value = 8'(color >> (8 * (panel_pkg::BYTES_PER_PIXEL - 1 - p)));
                    addr.row = panel_pkg::row_addr_t'(r);
                    addr.col = panel_pkg::col_addr_t'(c);
                    addr.pixel = panel_pkg::pixel_byte_t'(p);
                    exp_addr.push_back(addr);
                    exp_data.push_back(value);
                    model[model_index(r, c, p)] = value;   // Later fills overwrite earlier ones
                    written[model_index(r, c, p)] = 1'b1;
                end
            end
        end
    endfunction

    always @(posedge clk) begin
        closing = 1'b0;
        if (reset) begin
            byte_count = 0;
            fills_pending = 0;
            write_errors = 0;
            scan_errors = 0;
            other_errors = 0;
            end_done <= 1'b0;
            exp_addr.delete();
            exp_data.delete();
        end else begin
            if (enable && ready_for_data) begin
                cmd_bytes[byte_count] = data_in;
                byte_count++;
                if (byte_count == panel_pkg::CMD_BYTES) begin
                    queue_expected_writes(int'({cmd_bytes[0], cmd_bytes[1]}), int'(cmd_bytes[2]),
                                          int'({cmd_bytes[3], cmd_bytes[4]}), int'(cmd_bytes[5]),
                                          int'({cmd_bytes[6], cmd_bytes[7]}));
                    fills_pending++;
                    byte_count = 0;
                    closing = 1'b1;
                end
            end
            if (write_enable && exp_addr.size() == 0) begin
                other_errors++;
                $display("Unexpected write to address %h while no write was expected", write_addr);
            end else if (write_enable) begin
                if (write_addr !== exp_addr[0]) begin
                    write_errors++;
                    $display("MISMATCH write_addr: expected %h, got %h", exp_addr[0], write_addr);
                end
                if (write_data !== exp_data[0]) begin
                    write_errors++;
                    $display("MISMATCH write_data: expected %h, got %h", exp_data[0], write_data);
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
            if (ram_access_start && exp_addr.size() == 0) begin
                other_errors++;
                $display("ram_access_start pulsed for a fill with no writes");
            end
            if (access_q && !write_enable) begin
                other_errors++;
                $display("ram_access_start was not followed by a write in the next cycle");
            end
            if (write_enable && !write_q && !access_q) begin
                other_errors++;
                $display("Write burst began without ram_access_start in the cycle before");
            end
            if (closing_q && ready_for_data) begin
                other_errors++;
                $display("ready_for_data stayed high after the last command byte");
            end
            if (done_q && !ready_for_data) begin
                other_errors++;
                $display("ready_for_data did not return high in the cycle after done");
            end
            if (done && fills_pending == 0) begin
                other_errors++;
                $display("done pulsed with no command pending");
            end else if (done) begin
                fills_pending--;
                if (exp_addr.size() != 0) begin
                    other_errors++;
                    $display("done came with %0d expected writes still missing", exp_addr.size());
                end
            end
            if (rd_valid_q) begin
                index = model_index(int'(rd_addr_q.row), int'(rd_addr_q.col),
                                    int'(rd_addr_q.pixel));
                if (written[index] && scan_data !== model[index]) begin
                    scan_errors++;
                    $display("MISMATCH scan_data at %h: expected %h, got %h",
                             rd_addr_q, model[index], scan_data);
                end
            end
            if (end_check && !end_done) begin
                end_done <= 1'b1;
                if (fills_pending != 0 || exp_addr.size() != 0) begin
                    other_errors++;
                    $display("Run ended with %0d fills unfinished and %0d writes never seen",
                             fills_pending, exp_addr.size());
                end
            end
        end
        if (reset_q && (!ready_for_data || write_enable || ram_access_start || done)) begin
            other_errors++;
            $display("Outputs not at their reset values after reset");
        end
        reset_q <= reset;
        closing_q <= closing;
        done_q <= done;
        access_q <= ram_access_start;
        write_q <= write_enable;
        rd_valid_q <= scan_check;   // Scan data follows its address by one cycle
        rd_addr_q <= scan_addr;
    end

endmodule

`default_nettype wire

//--- test/panel_fill_tb.sv
// ========================================
// Directed clipping cases then 30 random fills; the full scan readback runs last
// ========================================
`default_nettype none

module panel_fill_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RANDOM_COMMANDS = 30;

    logic                clk;
    logic                reset;
    logic [7:0]          data_in;
    logic                enable;
    logic                ready_for_data;
    logic                done;
    logic                write_enable;
    panel_pkg::fb_addr_t write_addr;
    logic [7:0]          write_data;
    logic                ram_access_start;
    panel_pkg::fb_addr_t scan_addr;
    logic [7:0]          scan_data;
    logic                scan_check;
    logic                end_check;
    int                  write_errors;
    int                  scan_errors;
    int                  other_errors;
    int                  seed = 18;
    int                  limit_cycles = 0;
    logic                limit_ready = 1'b0;
    int                  cmd_x [$];
    int                  cmd_y [$];
    int                  cmd_w [$];
    int                  cmd_h [$];
    int                  cmd_color [$];

    panel_fill_top dut_i (.*);

    panel_fill_checker checker_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_command(input int x, input int y, input int w, input int h, input int c);
        cmd_x.push_back(x);
        cmd_y.push_back(y);
        cmd_w.push_back(w);
        cmd_h.push_back(h);
        cmd_color.push_back(c);
    endtask

    // Only sizes the watchdog
    function automatic int clipped_writes(input int x, input int y, input int w, input int h);
        int col_end;
        int row_end;
        if (x >= panel_pkg::PANEL_COLUMNS || y >= panel_pkg::PANEL_ROWS) begin
            return 0;
        end
        col_end = (x + w > panel_pkg::PANEL_COLUMNS) ? panel_pkg::PANEL_COLUMNS : x + w;
        row_end = (y + h > panel_pkg::PANEL_ROWS) ? panel_pkg::PANEL_ROWS : y + h;
        return (col_end - x) * (row_end - y) * panel_pkg::BYTES_PER_PIXEL;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        @(negedge clk);
        while (!ready_for_data) begin
            @(negedge clk);
        end
        data_in = value;
        enable = 1'b1;
    endtask

    task automatic run_command(input int i);
        send_byte(8'(cmd_x[i] >> 8));
        send_byte(8'(cmd_x[i]));
        send_byte(8'(cmd_y[i]));
        send_byte(8'(cmd_w[i] >> 8));
        send_byte(8'(cmd_w[i]));
        send_byte(8'(cmd_h[i]));
        send_byte(8'(cmd_color[i] >> 8));
        send_byte(8'(cmd_color[i]));
        @(negedge clk);
        while (!done) begin
            enable = 1'($random(seed));   // Junk strobes while the engine is busy
            data_in = 8'($random(seed));
            @(negedge clk);
        end
        enable = 1'b0;
    endtask

    task automatic scan_readback();
        for (int r = 0; r < panel_pkg::PANEL_ROWS; r++) begin
            for (int c = 0; c < panel_pkg::PANEL_COLUMNS; c++) begin
                for (int p = 0; p < panel_pkg::BYTES_PER_PIXEL; p++) begin
                    @(negedge clk);
                    scan_addr.row = panel_pkg::row_addr_t'(r);
                    scan_addr.col = panel_pkg::col_addr_t'(c);
                    scan_addr.pixel = panel_pkg::pixel_byte_t'(p);
                    scan_check = 1'b1;
                end
            end
        end
        @(negedge clk);
        scan_check = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        data_in = '0;
        enable = 1'b0;
        scan_addr = '0;
        scan_check = 1'b0;
        end_check = 1'b0;
        add_command(10, 3, 5, 4, 16'hf81f);
        add_command(316, 0, 10, 2, 16'h07e0);   // Crosses the right edge
        add_command(0, 30, 3, 8, 16'h001f);
        add_command(318, 31, 5, 5, 16'hffff);
        add_command(320, 0, 4, 4, 16'h1234);    // Starts beyond the right edge
        add_command(1000, 2, 4, 4, 16'h5678);
        add_command(4, 40, 4, 4, 16'h9abc);
        add_command(20, 8, 0, 4, 16'hdead);
        add_command(20, 8, 4, 0, 16'hbeef);
        add_command(0, 5, 65535, 1, 16'h0f0f);
        for (int i = 0; i < RANDOM_COMMANDS; i++) begin
            add_command({$random(seed)} % 340, {$random(seed)} % 36, 1 + {$random(seed)} % 40,
                        1 + {$random(seed)} % 12, {$random(seed)} % 65536);
        end
        foreach (cmd_x[i]) begin
            limit_cycles += clipped_writes(cmd_x[i], cmd_y[i], cmd_w[i], cmd_h[i]) + 20;
        end
        limit_cycles = (limit_cycles + panel_pkg::FB_DEPTH + 20) * 3 / 2;
        limit_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (cmd_x[i]) begin
            run_command(i);
        end
        scan_readback();
        @(negedge clk);
        end_check = 1'b1;
        repeat (2) @(negedge clk);
        $display("Errors: %0d write, %0d readback, %0d other",
                 write_errors, scan_errors, other_errors);
        if (write_errors + scan_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
